// ==== exu_testdata.txt ====
# name pc inst imm op1 op2 opj alu_op rd flags, flags in binary: ren wen jen ben sys csr_wen ecall mret ebreak
# expected: reg_wdata npc_wdata branch_change ebreak; every other column is hex
add       00000100 00000000 00000004 00001234 00000fff 00000100 0 1 000000000 00002233 00000104 0 0
sub       00000104 00000000 00000004 00000010 00000020 00000104 1 2 000000000 fffffff0 00000108 0 0
xor       00000108 00000000 00000004 f0f0f0f0 ff00ff00 00000108 2 3 000000000 0ff00ff0 0000010c 0 0
or        0000010c 00000000 00000004 f0f0f0f0 0f000f00 0000010c 3 4 000000000 fff0fff0 00000110 0 0
and       00000110 00000000 00000004 f0f0f0f0 ff00ff00 00000110 4 5 000000000 f000f000 00000114 0 0
sll       00000114 00000000 00000004 00000001 00000024 00000114 5 6 000000000 00000010 00000118 0 0
srl       00000118 00000000 00000004 80000000 0000001f 00000118 6 7 000000000 00000001 0000011c 0 0
sra       0000011c 00000000 00000004 80000000 00000004 0000011c 7 8 000000000 f8000000 00000120 0 0
slt       00000120 00000000 00000004 ffffffff 00000001 00000120 8 9 000000000 00000001 00000124 0 0
sltu      00000124 00000000 00000004 ffffffff 00000001 00000124 9 a 000000000 00000000 00000128 0 0
sge       00000128 00000000 00000004 00000005 fffffffb 00000128 a b 000000000 00000001 0000012c 0 0
sgeu      0000012c 00000000 00000004 00000005 fffffffb 0000012c b c 000000000 00000000 00000130 0 0
add_rd0   00000130 00000000 00000004 00000005 00000006 00000130 0 0 000000000 00000000 00000134 0 0
beq_t     00000200 00000000 00000010 00000007 00000007 00000200 1 0 000100000 00000000 00000210 1 0
bne_nt    00000204 00000000 fffffff8 00000007 00000007 00000204 2 0 000100000 00000000 000001fc 0 0
blt_t     00000208 00000000 00000020 fffffffe 00000001 00000208 8 0 000100000 00000000 00000228 1 0
bltu_nt   0000020c 00000000 00000020 fffffffe 00000001 0000020c 9 0 000100000 00000000 0000022c 0 0
bge_t     00000210 00000000 00000040 00000003 00000003 00000210 a 0 000100000 00000000 00000250 1 0
bgeu_nt   00000214 00000000 0000000c 00000001 ffffffff 00000214 b 0 000100000 00000000 00000220 0 0
jal       00000300 00000000 00000080 00000300 00000004 00000300 0 1 001000000 00000304 00000380 1 0
jalr      00000304 00000000 00000024 00000304 00000004 00001000 0 5 001000000 00000308 00001024 1 0
sw        00000380 00000000 00000010 00000080 cafef00d 00000080 0 0 010000000 00000000 00000090 0 0
lw        00000384 00000000 00000008 00000088 00000000 00000088 0 3 100000000 cafef00d 00000090 0 0
csrrw     00000388 305312f3 00000305 00000800 00000000 00000000 0 5 000011000 00000000 00000305 0 0
csrrs     0000038c 3053a373 00000305 0000000c 00000000 00000000 0 6 000011000 00000800 00000305 0 0
csrrc     00000390 305433f3 00000305 00000004 00000000 00000000 0 7 000011000 0000080c 00000305 0 0
csrrsi    00000394 30506473 00000305 00000000 00000000 00000000 0 8 000011000 00000808 00000305 0 0
ecall     00000400 00000073 00000000 00000000 00000000 00000000 0 0 000010100 00000000 00000808 1 0
rd_mepc   00000404 341024f3 00000341 00000000 00000000 00000000 0 9 000011000 00000400 00000341 0 0
rd_mcause 00000408 34202573 00000342 00000000 00000000 00000000 0 a 000011000 0000000b 00000342 0 0
mret      0000040c 30200073 00000000 00000000 00000000 00000000 0 0 000010010 00000000 00000400 1 0
ebreak    00000410 00100073 00000000 00000000 00000000 00000410 0 0 000010001 00000000 00000410 0 1

// ==== all.f ====
exu_pkg.sv
exu_alu.sv
exu_csr.sv
exu_stage.sv
exu_lsu.sv
exu_top.sv
tb_exu.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_exu -f all.f
./obj_dir/Vtb_exu | tee sim.log
if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

// ==== tb_exu.sv ====
`timescale 1ns/10ps

module tb_exu
  import exu_pkg::*;
();

  localparam int    CLK_PERIOD  = 100;
  localparam int    DRIVE_DLY   = 10;
  localparam int    RST_CYCLES  = 16;
  localparam int    CYC_PER_VEC = 200;
  localparam int    MAX_VEC     = 64;
  localparam string DATA_FILE   = "exu_testdata.txt";

  logic                 clk;
  logic                 rst;
  logic [31:0]          pc_i;
  logic [31:0]          inst_i;
  logic [31:0]          imm_i;
  logic [31:0]          op1_i;
  logic [31:0]          op2_i;
  logic [31:0]          opj_i;
  alu_op_e              alu_op_i;
  logic [REG_IDX_W-1:0] rd_i;
  logic                 ren_i, wen_i, jen_i, ben_i;
  logic                 system_i, csr_wen_i, ecall_i, mret_i, ebreak_i;
  logic                 prev_valid_i;
  logic                 ready_o;
  logic                 valid_o;
  logic                 next_ready_i;
  logic [31:0]          reg_wdata_o;
  logic [31:0]          npc_wdata_o;
  logic                 branch_change_o;
  logic [REG_IDX_W-1:0] rd_o;
  logic                 ebreak_o;

  // One entry per line of the data file.
  string        v_name  [MAX_VEC];
  logic [31:0]  v_pc    [MAX_VEC];
  logic [31:0]  v_inst  [MAX_VEC];
  logic [31:0]  v_imm   [MAX_VEC];
  logic [31:0]  v_op1   [MAX_VEC];
  logic [31:0]  v_op2   [MAX_VEC];
  logic [31:0]  v_opj   [MAX_VEC];
  logic [3:0]   v_alu   [MAX_VEC];
  logic [3:0]   v_rd    [MAX_VEC];
  logic [8:0]   v_flags [MAX_VEC];
  logic [31:0]  v_reg   [MAX_VEC];
  logic [31:0]  v_npc   [MAX_VEC];
  logic         v_bc    [MAX_VEC];
  logic         v_eb    [MAX_VEC];

  int          nvec;
  int          rcv;
  int          errors;
  int          tests_passed;
  int          tests_failed;
  bit          loaded;
  bit          load_ok;
  logic [31:0] rng;

  exu_top dut (
    .clk            (clk),
    .rst            (rst),
    .pc_i           (pc_i),
    .inst_i         (inst_i),
    .imm_i          (imm_i),
    .op1_i          (op1_i),
    .op2_i          (op2_i),
    .opj_i          (opj_i),
    .alu_op_i       (alu_op_i),
    .rd_i           (rd_i),
    .ren_i          (ren_i),
    .wen_i          (wen_i),
    .jen_i          (jen_i),
    .ben_i          (ben_i),
    .system_i       (system_i),
    .csr_wen_i      (csr_wen_i),
    .ecall_i        (ecall_i),
    .mret_i         (mret_i),
    .ebreak_i       (ebreak_i),
    .prev_valid_i   (prev_valid_i),
    .ready_o        (ready_o),
    .valid_o        (valid_o),
    .next_ready_i   (next_ready_i),
    .reg_wdata_o    (reg_wdata_o),
    .npc_wdata_o    (npc_wdata_o),
    .branch_change_o(branch_change_o),
    .rd_o           (rd_o),
    .ebreak_o       (ebreak_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  ////////////////////
  // Vector file
  ////////////////////

  task automatic read_vectors();
    int           fd;
    int           n;
    string        line;
    string        name;
    logic [31:0]  pc, inst, imm, op1, op2, opj, e_reg, e_npc;
    logic [3:0]   alu, rd;
    logic [8:0]   flags;
    logic         bc, eb;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("Error: cannot open %0s", DATA_FILE);
      load_ok = 1'b0;
    end else begin
      load_ok = 1'b1;
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        // Lines that start with a hash describe the columns.
        if (line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %b %h %h %h %h", name, pc, inst,
                      imm, op1, op2, opj, alu, rd, flags, e_reg, e_npc, bc, eb);
          if (n == 14 && nvec < MAX_VEC) begin
            v_name[nvec]  = name;
            v_pc[nvec]    = pc;
            v_inst[nvec]  = inst;
            v_imm[nvec]   = imm;
            v_op1[nvec]   = op1;
            v_op2[nvec]   = op2;
            v_opj[nvec]   = opj;
            v_alu[nvec]   = alu;
            v_rd[nvec]    = rd;
            v_flags[nvec] = flags;
            v_reg[nvec]   = e_reg;
            v_npc[nvec]   = e_npc;
            v_bc[nvec]    = bc;
            v_eb[nvec]    = eb;
            nvec++;
          end else if (n > 0) begin
            $display("Error: a line of %0s could not be read as a test vector", DATA_FILE);
            errors++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////
  // Driving
  ////////////////////

  task automatic stall_writeback();
    int stall;
    rng = xorshift32(rng);
    stall = 1 + int'(rng[0]);
    next_ready_i = 1'b0;
    repeat (stall) begin
      @(posedge clk);
      #DRIVE_DLY;
    end
    next_ready_i = 1'b1;
  endtask

  task automatic send_vector(input int k);
    pc_i         = v_pc[k];
    inst_i       = v_inst[k];
    imm_i        = v_imm[k];
    op1_i        = v_op1[k];
    op2_i        = v_op2[k];
    opj_i        = v_opj[k];
    alu_op_i     = alu_op_e'(v_alu[k]);
    rd_i         = v_rd[k];
    {ren_i, wen_i, jen_i, ben_i, system_i} = v_flags[k][8:4];
    {csr_wen_i, ecall_i, mret_i, ebreak_i} = v_flags[k][3:0];
    prev_valid_i = 1'b1;
    // Every third result is stalled while the next instruction is already offered.
    if (k > 0 && (k - 1) % 3 == 2) begin
      stall_writeback();
    end
    // Ready seen at the falling edge means the next rising edge accepts.
    @(negedge clk);
    while (!ready_o) begin
      @(negedge clk);
    end
    @(posedge clk);
    #DRIVE_DLY;
    prev_valid_i = 1'b0;
  endtask

  ////////////////////
  // Checking
  ////////////////////

  task automatic compare_value(input int k, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Mismatch %0s %0s: expected %h, actual %h", v_name[k], field, expected, actual);
      errors++;
    end
  endtask

  task automatic check_result(input int k);
    int errs_before;
    errs_before = errors;
    compare_value(k, "reg_wdata", v_reg[k], reg_wdata_o);
    compare_value(k, "npc_wdata", v_npc[k], npc_wdata_o);
    compare_value(k, "branch_change", 32'(v_bc[k]), 32'(branch_change_o));
    compare_value(k, "ebreak", 32'(v_eb[k]), 32'(ebreak_o));
    compare_value(k, "rd", 32'(v_rd[k]), 32'(rd_o));
    if (errors == errs_before) begin
      tests_passed++;
      $display("test %0d %0s: ok", k, v_name[k]);
    end else begin
      tests_failed++;
      $display("test %0d %0s: wrong result", k, v_name[k]);
    end
  endtask

  // A result seen at the falling edge is consumed at the next rising edge.
  initial begin
    forever begin
      @(negedge clk);
      if (!rst && valid_o && next_ready_i) begin
        if (rcv < nvec) begin
          check_result(rcv);
        end else begin
          $display("Error: the DUT returned a result with no instruction left to match it");
          errors++;
        end
        rcv++;
      end
    end
  end

  initial begin
    wait (loaded);
    repeat (RST_CYCLES + CYC_PER_VEC * nvec) @(posedge clk);
    $display("Timeout: only %0d of %0d results arrived within %0d cycles", rcv, nvec,
             RST_CYCLES + CYC_PER_VEC * nvec);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    rst          = 1'b1;
    pc_i         = '0;
    inst_i       = '0;
    imm_i        = '0;
    op1_i        = '0;
    op2_i        = '0;
    opj_i        = '0;
    alu_op_i     = ALU_ADD;
    rd_i         = '0;
    {ren_i, wen_i, jen_i, ben_i, system_i} = '0;
    {csr_wen_i, ecall_i, mret_i, ebreak_i} = '0;
    prev_valid_i = 1'b0;
    next_ready_i = 1'b1;
    nvec         = 0;
    rcv          = 0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    loaded       = 1'b0;
    rng          = 32'd95;
    read_vectors();
    if (!load_ok || nvec == 0) begin
      $display("Error: no test vectors were loaded from %0s", DATA_FILE);
      $display("*** FAILED ***");
      $finish;
    end else begin
      loaded = 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      #DRIVE_DLY;
      rst = 1'b0;
      for (int k = 0; k < nvec; k++) begin
        send_vector(k);
      end
      if ((nvec - 1) % 3 == 2) begin
        stall_writeback();
      end
      wait (rcv >= nvec);
      // A few idle cycles expose any duplicated result.
      repeat (4) @(posedge clk);
      $display("Summary: %0d vectors, %0d results, %0d passed, %0d failed, %0d errors",
               nvec, rcv, tests_passed, tests_failed, errors);
      if (errors == 0 && tests_failed == 0 && rcv == nvec) begin
        $display("*** PASSED ***");
      end else begin
        $display("*** FAILED ***");
      end
      $finish;
    end
  end

endmodule

// ==== exu_top.sv ====
`timescale 1ns/10ps

module exu_top
  import exu_pkg::*;
#(
  parameter int XLEN        = 32,
  parameter int MEM_WORDS   = 256,
  parameter int MEM_LATENCY = 3
) (
  input  logic                 clk,
  input  logic                 rst,

  input  logic [XLEN-1:0]      pc_i,
  input  logic [31:0]          inst_i,
  input  logic [XLEN-1:0]      imm_i,
  input  logic [XLEN-1:0]      op1_i,
  input  logic [XLEN-1:0]      op2_i,
  input  logic [XLEN-1:0]      opj_i,
  input  alu_op_e              alu_op_i,
  input  logic [REG_IDX_W-1:0] rd_i,
  input  logic                 ren_i,
  input  logic                 wen_i,
  input  logic                 jen_i,
  input  logic                 ben_i,
  input  logic                 system_i,
  input  logic                 csr_wen_i,
  input  logic                 ecall_i,
  input  logic                 mret_i,
  input  logic                 ebreak_i,
  input  logic                 prev_valid_i,
  output logic                 ready_o,

  output logic                 valid_o,
  input  logic                 next_ready_i,
  output logic [XLEN-1:0]      reg_wdata_o,
  output logic [XLEN-1:0]      npc_wdata_o,
  output logic                 branch_change_o,
  output logic [REG_IDX_W-1:0] rd_o,
  output logic                 ebreak_o
);

  logic            mem_req;
  logic            mem_we;
  logic [XLEN-1:0] mem_addr;
  logic [XLEN-1:0] mem_wdata;
  logic            mem_rvalid;
  logic            mem_wready;
  logic [XLEN-1:0] mem_rdata;

  exu_stage #(
    .XLEN(XLEN)
  ) u_stage (
    .clk            (clk),
    .rst            (rst),
    .pc_i           (pc_i),
    .inst_i         (inst_i),
    .imm_i          (imm_i),
    .op1_i          (op1_i),
    .op2_i          (op2_i),
    .opj_i          (opj_i),
    .alu_op_i       (alu_op_i),
    .rd_i           (rd_i),
    .ren_i          (ren_i),
    .wen_i          (wen_i),
    .jen_i          (jen_i),
    .ben_i          (ben_i),
    .system_i       (system_i),
    .csr_wen_i      (csr_wen_i),
    .ecall_i        (ecall_i),
    .mret_i         (mret_i),
    .ebreak_i       (ebreak_i),
    .prev_valid_i   (prev_valid_i),
    .ready_o        (ready_o),
    .mem_req_o      (mem_req),
    .mem_we_o       (mem_we),
    .mem_addr_o     (mem_addr),
    .mem_wdata_o    (mem_wdata),
    .mem_rvalid_i   (mem_rvalid),
    .mem_wready_i   (mem_wready),
    .mem_rdata_i    (mem_rdata),
    .valid_o        (valid_o),
    .next_ready_i   (next_ready_i),
    .reg_wdata_o    (reg_wdata_o),
    .npc_wdata_o    (npc_wdata_o),
    .branch_change_o(branch_change_o),
    .rd_o           (rd_o),
    .ebreak_o       (ebreak_o)
  );

  exu_lsu #(
    .XLEN       (XLEN),
    .MEM_WORDS  (MEM_WORDS),
    .MEM_LATENCY(MEM_LATENCY)
  ) u_lsu (
    .clk     (clk),
    .rst     (rst),
    .req_i   (mem_req),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .rvalid_o(mem_rvalid),
    .wready_o(mem_wready),
    .rdata_o (mem_rdata)
  );

endmodule

// ==== exu_lsu.sv ====
`timescale 1ns/10ps

module exu_lsu #(
  parameter int XLEN        = 32,
  parameter int MEM_WORDS   = 256,
  parameter int MEM_LATENCY = 2
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            req_i,
  input  logic            we_i,
  input  logic [XLEN-1:0] addr_i,
  input  logic [XLEN-1:0] wdata_i,
  output logic            rvalid_o,
  output logic            wready_o,
  output logic [XLEN-1:0] rdata_o
);

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int CNT_W = $clog2(MEM_LATENCY + 1);

  logic [XLEN-1:0]  mem [MEM_WORDS];
  logic             busy;
  logic [CNT_W-1:0] cnt;
  logic             start;
  logic             fire;
  logic [XLEN-1:0]  word_addr;
  logic [IDX_W-1:0] idx;

  assign word_addr = (addr_i >> 2) % MEM_WORDS;
  assign idx       = word_addr[IDX_W-1:0];

  // The request is still high while its response pulse is out, so it is not
  // taken as a new one then.
  assign start = !busy && req_i && !rvalid_o && !wready_o;
  assign fire  = busy ? (cnt == CNT_W'(1)) : (start && MEM_LATENCY == 1);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      cnt      <= '0;
      rvalid_o <= 1'b0;
      wready_o <= 1'b0;
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else begin
      rvalid_o <= 1'b0;
      wready_o <= 1'b0;
      if (start && MEM_LATENCY > 1) begin
        busy <= 1'b1;
        cnt  <= CNT_W'(MEM_LATENCY - 1);
      end else if (busy && !fire) begin
        cnt <= cnt - 1'b1;
      end
      if (fire) begin
        busy <= 1'b0;
        if (we_i) begin
          mem[idx] <= wdata_i;
          wready_o <= 1'b1;
        end else begin
          rvalid_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire && !we_i) begin
      rdata_o <= mem[idx];
    end
  end

  // The stage must keep its request up until the response.
  a_req_held: assert property (@(posedge clk) disable iff (rst)
    busy |-> req_i);

endmodule

// ==== exu_stage.sv ====
`timescale 1ns/10ps

module exu_stage
  import exu_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic                 clk,
  input  logic                 rst,

  input  logic [XLEN-1:0]      pc_i,
  input  logic [31:0]          inst_i,
  input  logic [XLEN-1:0]      imm_i,
  input  logic [XLEN-1:0]      op1_i,
  input  logic [XLEN-1:0]      op2_i,
  input  logic [XLEN-1:0]      opj_i,
  input  alu_op_e              alu_op_i,
  input  logic [REG_IDX_W-1:0] rd_i,
  input  logic                 ren_i,
  input  logic                 wen_i,
  input  logic                 jen_i,
  input  logic                 ben_i,
  input  logic                 system_i,
  input  logic                 csr_wen_i,
  input  logic                 ecall_i,
  input  logic                 mret_i,
  input  logic                 ebreak_i,
  input  logic                 prev_valid_i,
  output logic                 ready_o,

  output logic                 mem_req_o,
  output logic                 mem_we_o,
  output logic [XLEN-1:0]      mem_addr_o,
  output logic [XLEN-1:0]      mem_wdata_o,
  input  logic                 mem_rvalid_i,
  input  logic                 mem_wready_i,
  input  logic [XLEN-1:0]      mem_rdata_i,

  output logic                 valid_o,
  input  logic                 next_ready_i,
  output logic [XLEN-1:0]      reg_wdata_o,
  output logic [XLEN-1:0]      npc_wdata_o,
  output logic                 branch_change_o,
  output logic [REG_IDX_W-1:0] rd_o,
  output logic                 ebreak_o
);

  logic [XLEN-1:0] pc_r;
  logic [XLEN-1:0] imm_r;
  logic [XLEN-1:0] src1_r;
  logic [XLEN-1:0] src2_r;
  logic [XLEN-1:0] opj_r;
  alu_op_e         alu_op_r;
  csr_f3_e         f3_r;
  logic            ren_r, wen_r, jen_r, ben_r;
  logic            system_r, csr_wen_r, ecall_r, mret_r;

  logic            ready_r;
  logic            valid_r;
  logic            req_r;
  logic [XLEN-1:0] mem_rdata_r;
  logic            accept;
  logic            consume;
  logic            mem_resp;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] target;
  logic [XLEN-1:0] csr_rdata;
  logic [XLEN-1:0] csr_wdata;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mtvec;

  assign accept   = prev_valid_i & ready_o;
  assign consume  = valid_o & next_ready_i;
  assign mem_resp = req_r & ((ren_r & mem_rvalid_i) | (wen_r & mem_wready_i));

  // Nothing enters while writeback stalls.
  assign ready_o = ready_r & next_ready_i;
  assign valid_o = valid_r;

  ////////////////////
  // Handshake and memory sequencing
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      ready_r   <= 1'b1;
      valid_r   <= 1'b0;
      req_r     <= 1'b0;
      ren_r     <= 1'b0;
      wen_r     <= 1'b0;
      jen_r     <= 1'b0;
      ben_r     <= 1'b0;
      system_r  <= 1'b0;
      csr_wen_r <= 1'b0;
      ecall_r   <= 1'b0;
      mret_r    <= 1'b0;
      ebreak_o  <= 1'b0;
    end else begin
      if (accept) begin
        ren_r     <= ren_i;
        wen_r     <= wen_i;
        jen_r     <= jen_i;
        ben_r     <= ben_i;
        system_r  <= system_i;
        csr_wen_r <= csr_wen_i;
        ecall_r   <= ecall_i;
        mret_r    <= mret_i;
        ebreak_o  <= ebreak_i;
        if (ren_i | wen_i) begin
          ready_r <= 1'b0;
          req_r   <= 1'b1;
          valid_r <= 1'b0;
        end else begin
          valid_r <= 1'b1;
        end
      end else if (consume) begin
        valid_r <= 1'b0;
      end
      // The response can only arrive while ready is low, never with an accept.
      if (mem_resp) begin
        req_r   <= 1'b0;
        ready_r <= 1'b1;
        valid_r <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pc_r     <= pc_i;
      imm_r    <= imm_i;
      src1_r   <= op1_i;
      src2_r   <= op2_i;
      opj_r    <= opj_i;
      alu_op_r <= alu_op_i;
      f3_r     <= csr_f3_e'(inst_i[14:12]);
      rd_o     <= rd_i;
    end
    if (mem_resp && ren_r) begin
      mem_rdata_r <= mem_rdata_i;
    end
  end

  assign target      = opj_r + imm_r;
  assign mem_req_o   = req_r;
  assign mem_we_o    = wen_r;
  assign mem_addr_o  = target;
  assign mem_wdata_o = src2_r;

  ////////////////////
  // Datapath
  ////////////////////

  exu_alu #(
    .XLEN(XLEN)
  ) u_alu (
    .src1_i(src1_r),
    .src2_i(src2_r),
    .op_i  (alu_op_r),
    .res_o (alu_res)
  );

  // The CSR address sits in the low twelve bits of the I-type immediate.
  exu_csr #(
    .XLEN(XLEN)
  ) u_csr (
    .clk     (clk),
    .rst     (rst),
    .commit_i(consume),
    .wen_i   (csr_wen_r),
    .ecall_i (ecall_r),
    .mret_i  (mret_r),
    .addr_i  (imm_r[11:0]),
    .wdata_i (csr_wdata),
    .pc_i    (pc_r),
    .rdata_o (csr_rdata),
    .mepc_o  (mepc),
    .mtvec_o (mtvec)
  );

  always_comb begin
    case (f3_r)
      F3_CSRRW, F3_CSRRWI: csr_wdata = src1_r;
      F3_CSRRS, F3_CSRRSI: csr_wdata = csr_rdata | src1_r;
      F3_CSRRC, F3_CSRRCI: csr_wdata = csr_rdata & ~src1_r;
      default:             csr_wdata = '0;
    endcase
  end

  always_comb begin
    if (rd_o == '0) begin
      reg_wdata_o = '0;
    end else if (ren_r) begin
      reg_wdata_o = mem_rdata_r;
    end else if (system_r) begin
      reg_wdata_o = csr_rdata;
    end else begin
      reg_wdata_o = alu_res;
    end
  end

  assign npc_wdata_o = ecall_r ? mtvec : (mret_r ? mepc : target);

  // BEQ and BNE use SUB and XOR, the rest map to a compare.
  always_comb begin
    if (ben_r) begin
      case (alu_op_r)
        ALU_SUB:  branch_change_o = ~|alu_res;
        ALU_XOR, ALU_SLT, ALU_SLTU, ALU_SGE, ALU_SGEU: branch_change_o = |alu_res;
        default:  branch_change_o = 1'b0;
      endcase
    end else begin
      branch_change_o = ecall_r | mret_r | jen_r;
    end
  end

  a_ld_st_excl: assert property (@(posedge clk) disable iff (rst)
    !(ren_r && wen_r));

  // A stalled result must be presented unchanged until writeback takes it.
  a_wb_hold: assert property (@(posedge clk) disable iff (rst)
    valid_o && !next_ready_i |=> valid_o && $stable(reg_wdata_o)
      && $stable(npc_wdata_o) && $stable(branch_change_o));

endmodule

// ==== exu_csr.sv ====
`timescale 1ns/10ps

module exu_csr
  import exu_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            commit_i,
  input  logic            wen_i,
  input  logic            ecall_i,
  input  logic            mret_i,
  input  logic [11:0]     addr_i,
  input  logic [XLEN-1:0] wdata_i,
  input  logic [XLEN-1:0] pc_i,
  output logic [XLEN-1:0] rdata_o,
  output logic [XLEN-1:0] mepc_o,
  output logic [XLEN-1:0] mtvec_o
);

  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mcause;

  always_ff @(posedge clk) begin
    if (rst) begin
      mepc   <= '0;
      mtvec  <= '0;
      mcause <= '0;
    end else if (commit_i) begin
      if (wen_i) begin
        case (addr_i)
          CSR_MEPC:   mepc   <= wdata_i;
          CSR_MTVEC:  mtvec  <= wdata_i;
          CSR_MCAUSE: mcause <= wdata_i;
          default: ;
        endcase
      end
      // Trap entry wins over a CSR write in the same commit.
      if (ecall_i) begin
        mepc   <= pc_i;
        mcause <= XLEN'(MCAUSE_ECALL_M);
      end
    end
  end

  always_comb begin
    case (addr_i)
      CSR_MEPC:   rdata_o = mepc;
      CSR_MTVEC:  rdata_o = mtvec;
      CSR_MCAUSE: rdata_o = mcause;
      default:    rdata_o = '0;
    endcase
  end

  // MRET reads mepc through this port and leaves the CSRs alone.
  assign mepc_o  = mepc;
  assign mtvec_o = mtvec;

  // Decode marks at most one trap kind per instruction.
  a_trap_onehot: assert property (@(posedge clk) disable iff (rst)
    !(ecall_i && mret_i));

endmodule

// ==== exu_alu.sv ====
`timescale 1ns/10ps

module exu_alu
  import exu_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic [XLEN-1:0] src1_i,
  input  logic [XLEN-1:0] src2_i,
  input  alu_op_e         op_i,
  output logic [XLEN-1:0] res_o
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = src2_i[4:0];
  assign lt_s  = $signed(src1_i) < $signed(src2_i);
  assign lt_u  = src1_i < src2_i;

  always_comb begin
    case (op_i)
      ALU_ADD:  res_o = src1_i + src2_i;
      ALU_SUB:  res_o = src1_i - src2_i;
      ALU_XOR:  res_o = src1_i ^ src2_i;
      ALU_OR:   res_o = src1_i | src2_i;
      ALU_AND:  res_o = src1_i & src2_i;
      ALU_SLL:  res_o = src1_i << shamt;
      ALU_SRL:  res_o = src1_i >> shamt;
      ALU_SRA:  res_o = $unsigned($signed(src1_i) >>> shamt);
      // Compares give a single bit, zero extended.
      ALU_SLT:  res_o = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: res_o = {{(XLEN-1){1'b0}}, lt_u};
      ALU_SGE:  res_o = {{(XLEN-1){1'b0}}, ~lt_s};
      ALU_SGEU: res_o = {{(XLEN-1){1'b0}}, ~lt_u};
      default:  res_o = '0;
    endcase
  end

endmodule

// ==== exu_pkg.sv ====
package exu_pkg;

  // RV32E has sixteen integer registers.
  localparam int REG_IDX_W = 4;

  ////////////////////
  // ALU operations
  ////////////////////

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_XOR  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_AND  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_SGE  = 4'd10,
    ALU_SGEU = 4'd11
  } alu_op_e;

  ////////////////////
  // CSR instructions
  ////////////////////

  // Encoded as in funct3 of the SYSTEM opcode.
  typedef enum logic [2:0] {
    F3_CSRRW  = 3'b001,
    F3_CSRRS  = 3'b010,
    F3_CSRRC  = 3'b011,
    F3_CSRRWI = 3'b101,
    F3_CSRRSI = 3'b110,
    F3_CSRRCI = 3'b111
  } csr_f3_e;

  localparam logic [11:0] CSR_MTVEC  = 12'h305;
  localparam logic [11:0] CSR_MEPC   = 12'h341;
  localparam logic [11:0] CSR_MCAUSE = 12'h342;

  // Environment call from M-mode.
  localparam int unsigned MCAUSE_ECALL_M = 11;

endpackage
